// File: verif/display_vectors.txt
// name vis new_pxl col row rgbmode f1 c1 p1 f2 c2 p2 pix1 pix2 exp_rgb
// col and row decimal, rest hex; f/c/p are filter, centroid, proximity of cam1 and cam2
blank_left     0 0 10  10  1 5 aa 5 3 55 3 123 abc 000
blank_right    0 0 300 50  1 5 aa 5 3 55 3 123 abc 000
blank_box      0 0 26  130 1 5 aa 5 3 55 3 123 abc 000
img_rgb_l0     1 0 0   0   1 5 aa 5 3 55 3 123 abc abc
img_rgb_l1     1 0 159 119 1 5 aa 5 3 55 3 123 5e7 5e7
img_rgb_r0     1 0 256 0   1 5 aa 5 3 55 3 3c9 abc 3c9
img_rgb_r1     1 0 415 119 1 5 aa 5 3 55 3 f01 abc f01
img_gray_l     1 0 80  60  0 5 aa 5 3 55 3 123 abc bbb
img_gray_r     1 0 300 30  0 5 aa 5 3 55 3 3c9 abc ccc
img_gray_r1    1 0 415 5   0 5 aa 5 3 55 3 f01 abc 000
prox_l_p7_b0   1 0 160 0   1 5 aa 5 3 55 7 123 abc 0ff
prox_l_p0_b7   1 0 167 112 1 5 aa 5 3 55 0 123 abc 0ff
prox_l_p0_b6   1 0 163 100 1 5 aa 5 3 55 0 123 abc 000
prox_l_p3_b4   1 0 165 64  1 5 aa 5 3 55 3 123 abc 0ff
prox_l_p3_b3   1 0 165 48  1 5 aa 5 3 55 3 123 abc 000
prox_r_p5_b2   1 0 416 32  1 5 aa 5 3 55 3 123 abc f0f
prox_r_p5_b1   1 0 420 16  1 5 aa 5 3 55 3 123 abc 000
prox_r_p1_b7   1 0 423 119 1 5 aa 1 3 55 3 123 abc f0f
prox_r_p1_b5   1 0 418 80  1 5 aa 1 3 55 3 123 abc 000
cent_l_s0      1 0 5   120 1 5 aa 5 3 55 3 123 abc 0ff
cent_l_s1      1 0 25  121 1 5 aa 5 3 55 3 123 abc 000
cent_l_s2      1 0 45  122 1 5 aa 5 3 55 3 123 abc 0ff
cent_l_s3      1 0 65  123 1 5 aa 5 3 55 3 123 abc 000
cent_l_s4      1 0 85  124 1 5 aa 5 3 55 3 123 abc 0ff
cent_l_s5      1 0 105 125 1 5 aa 5 3 55 3 123 abc 000
cent_l_s6      1 0 125 126 1 5 aa 5 3 55 3 123 abc 0ff
cent_l_s7      1 0 159 127 1 5 aa 5 3 55 3 123 abc 000
cent_r_s0      1 0 256 120 1 5 aa 5 3 55 3 123 abc 000
cent_r_s1      1 0 276 121 1 5 aa 5 3 55 3 123 abc f0f
cent_r_s2      1 0 299 122 1 5 aa 5 3 55 3 123 abc 000
cent_r_s3      1 0 320 123 1 5 aa 5 3 55 3 123 abc f0f
cent_r_s4      1 0 340 124 1 5 aa 5 3 55 3 123 abc 000
cent_r_s5      1 0 360 125 1 5 aa 5 3 55 3 123 abc f0f
cent_r_s6      1 0 380 126 1 5 aa 5 3 55 3 123 abc 000
cent_r_s7      1 0 415 127 1 5 aa 5 3 55 3 123 abc f0f
box_l0         1 0 24  128 1 5 aa 5 3 55 3 123 abc 0ff
box_l1         1 0 31  135 1 5 aa 5 3 55 3 123 abc 0ff
box_l_f6       1 0 28  132 1 5 aa 5 6 55 3 123 abc ff0
box_r0         1 0 256 128 1 5 aa 5 3 55 3 123 abc f0f
box_r1         1 0 263 135 1 5 aa 5 3 55 3 123 abc f0f
box_r_f2       1 0 260 131 1 2 aa 5 3 55 3 123 abc 0f0
bg_gap         1 0 200 50  1 5 aa 5 3 55 3 123 abc 000
bg_right       1 0 424 10  1 5 aa 5 3 55 3 123 abc 000
bg_box_row     1 0 100 130 1 5 aa 5 3 55 3 123 abc 000
bg_box_r_edge  1 0 264 130 1 5 aa 5 3 55 3 123 abc 000
bg_below       1 0 30  136 1 5 aa 5 3 55 3 123 abc 000
bg_cent_gap    1 0 163 124 1 5 aa 5 3 55 3 123 abc 000
bg_far         1 0 639 479 1 5 aa 5 3 55 3 123 abc 000

// File: compile.f
verilog/display_pkg.sv
verilog/screen_layout_ctrl.sv
verilog/frame_addr_gen.sv
verilog/cam_pixel_fmt.sv
verilog/pixel_compose.sv
verilog/vga_display.sv
verif/tb_clock_gen.sv
verif/tb_vga_display.sv

// File: run_sim.sh
#!/bin/sh
# Builds the compositor testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f compile.f \
  --top-module tb_vga_display \
  -o tb_vga_display

# a failing run stops with a non-zero status, keep its output anyway
sim_out=$(./obj_dir/tb_vga_display 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Result: PASSED'; then
  exit 0
else
  exit 1
fi

// File: verif/tb_vga_display.sv
/*
  Testbench for the dual camera VGA compositor.
  First phase reads scan points and expected colours from
  verif/display_vectors.txt, drives them on the falling clock edge and
  checks vga_rgb. Second phase scans image rows with random new_pxl and
  tracks both frame addresses with its own counters.
*/
`timescale 1ns/10ps

module tb_vga_display;

  import display_pkg::*;

  localparam string vec_file      = "verif/display_vectors.txt";
  localparam int    time_limit_ns = 1_000_000;
  localparam int    reset_wait    = 10;   // clock periods
  localparam int    scan_rows     = 3;
  localparam int    vis_cols      = 640;
  localparam logic [31:0] lcg_seed = 32'hfa70_5d20;

  logic        rst;  // clock
  logic        clk;  // reset
  scan_pos_t   scan;
  logic        rgbmode;
  cam_status_t cam1_status;
  cam_status_t cam2_status;
  buf_pixel_t  frame_pixel_1;
  buf_pixel_t  frame_pixel_2;
  frame_addr_t frame_addr_1;
  frame_addr_t frame_addr_2;
  rgb444_t     vga_rgb;

  frame_addr_t exp_addr_1;  // model of camera 1 address
  frame_addr_t exp_addr_2;  // model of camera 2 address
  logic [31:0] lcg_state;
  int          n_vectors;

  tb_clock_gen #(
    .period_ns    (20),
    .reset_cycles (2)
  ) clock_gen_i (
    .rst (rst),
    .clk (clk)
  );

  vga_display vga_display_i (
    .rst           (rst),
    .clk           (clk),
    .scan          (scan),
    .rgbmode       (rgbmode),
    .cam1_status   (cam1_status),
    .cam2_status   (cam2_status),
    .frame_pixel_1 (frame_pixel_1),
    .frame_pixel_2 (frame_pixel_2),
    .frame_addr_1  (frame_addr_1),
    .frame_addr_2  (frame_addr_2),
    .vga_rgb       (vga_rgb)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rgb(input string test, input rgb444_t expected, input rgb444_t actual);
    if (actual !== expected)
      abort_run($sformatf("Fail %s: expected %h, actual %h", test, expected, actual));
  endtask

  task automatic check_addr(input string test, input frame_addr_t expected,
                            input frame_addr_t actual);
    if (actual !== expected)
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", test, expected, actual));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (clk !== 1'b0) begin
      @(negedge rst);
      cycles++;
      if (cycles > reset_wait)
        abort_run("reset was never released");
    end
  endtask

  // applies every line of the vector file, one per clock, starting on a falling edge
  task automatic run_vectors();
    int              fd;
    int              n_fields;
    int              line_no;
    string           line;
    logic [8*24-1:0] name;
    logic            vis;
    logic            npx;
    logic            rgb_sel;
    scr_col_t        col;
    scr_row_t        row;
    logic [2:0]      f1, f2, p1, p2;
    logic [7:0]      c1, c2;
    logic [11:0]     pix1, pix2, exp_bits;
    fd = $fopen(vec_file, "r");
    if (fd == 0)
      abort_run("cannot open the vector file");
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() < 4 || line.substr(0, 1) == "//")
        continue;  // comment or empty line
      n_fields = $sscanf(line, "%s %h %h %d %d %h %h %h %h %h %h %h %h %h %h",
                         name, vis, npx, col, row, rgb_sel, f1, c1, p1, f2, c2, p2,
                         pix1, pix2, exp_bits);
      if (n_fields != 15)
        abort_run($sformatf("vector line %0d has the wrong number of fields", line_no));
      scan.visible          = vis;
      scan.new_pxl          = npx;
      scan.col              = col;
      scan.row              = row;
      rgbmode               = rgb_sel;
      cam1_status.filter    = f1;
      cam1_status.centroid  = c1;
      cam1_status.proximity = p1;
      cam2_status.filter    = f2;
      cam2_status.centroid  = c2;
      cam2_status.proximity = p2;
      frame_pixel_1         = pix1;
      frame_pixel_2         = pix2;
      @(posedge rst);  // colour is combinational, stable here
      check_rgb($sformatf("%0s (line %0d)", name, line_no), rgb444_t'(exp_bits), vga_rgb);
      @(negedge rst);
      n_vectors++;
    end
    $fclose(fd);
    if (n_vectors == 0)
      abort_run("no vectors were read from the vector file");
  endtask

  // one scan point of the address test, checked one edge later
  task automatic scan_point(input logic npx, input int col, input int row);
    scan.visible = 1'b1;
    scan.new_pxl = npx;
    scan.col     = scr_col_t'(col);
    scan.row     = scr_row_t'(row);
    if (row >= def_img_rows) begin
      exp_addr_1 = '0;
      exp_addr_2 = '0;
    end
    else if (npx) begin
      if (col < def_img_cols)
        exp_addr_2 = exp_addr_2 + frame_addr_t'(1);
      else if (col >= def_cam_rght_col && col < def_cam_rght_col + def_img_cols)
        exp_addr_1 = exp_addr_1 + frame_addr_t'(1);
    end
    @(negedge rst);
    check_addr($sformatf("addr1 row %0d col %0d", row, col), exp_addr_1, frame_addr_1);
    check_addr($sformatf("addr2 row %0d col %0d", row, col), exp_addr_2, frame_addr_2);
  endtask

  initial begin
    #(time_limit_ns);
    abort_run("simulation ran past its time limit");
  end

  initial begin
    scan          = '0;
    rgbmode       = 1'b1;
    cam1_status   = '0;
    cam2_status   = '0;
    frame_pixel_1 = '0;
    frame_pixel_2 = '0;
    exp_addr_1    = '0;
    exp_addr_2    = '0;
    lcg_state     = lcg_seed;
    n_vectors     = 0;

    wait_reset_release();
    check_addr("reset addr1", '0, frame_addr_1);
    check_addr("reset addr2", '0, frame_addr_2);

    run_vectors();

    // rewind, then scan the top image rows
    scan_point(1'b0, 0, def_img_rows);
    for (int r = 0; r < scan_rows; r++) begin
      for (int c = 0; c < vis_cols; c++) begin
        lcg_state = lcg_next(lcg_state);
        scan_point(lcg_state[16], c, r);
      end
    end
    if (exp_addr_1 == '0 || exp_addr_2 == '0)
      abort_run("random new_pxl never stepped one of the addresses");
    scan_point(1'b1, 0, def_img_rows);  // both must clear

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
/*
  Clock and reset source for the compositor testbench.
  rst carries the free running clock, clk the active high reset that
  is held for the first reset_cycles clock periods.
*/
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 2
) (
  output logic rst,  // clock
  output logic clk   // reset
);

  initial begin
    rst = 1'b0;
    forever #(period_ns / 2) rst = ~rst;
  end

  initial begin
    clk = 1'b1;
    #(period_ns * reset_cycles);
    clk <= 1'b0;  // released on a falling edge
  end

endmodule

// File: verilog/vga_display.sv
/*
  Top level of the dual camera VGA compositor.
  Camera 2 shows on the left, camera 1 at cam_rght_col. The layout
  parameters are set here and passed to the layout control and the
  address counters. Colour out is combinational from the scan point and
  the buffer words, the frame addresses are registered.
*/
`timescale 1ns/10ps

module vga_display #(
  parameter int img_cols     = display_pkg::def_img_cols,
  parameter int img_rows     = display_pkg::def_img_rows,
  parameter int cam_rght_col = display_pkg::def_cam_rght_col
) (
  input  logic                     rst,            // clock
  input  logic                     clk,            // async reset, active high
  input  display_pkg::scan_pos_t   scan,
  input  logic                     rgbmode,        // 0 shows gray
  input  display_pkg::cam_status_t cam1_status,    // right camera
  input  display_pkg::cam_status_t cam2_status,    // left camera
  input  display_pkg::buf_pixel_t  frame_pixel_1,
  input  display_pkg::buf_pixel_t  frame_pixel_2,
  output display_pkg::frame_addr_t frame_addr_1,
  output display_pkg::frame_addr_t frame_addr_2,
  output display_pkg::rgb444_t     vga_rgb
);

  import display_pkg::*;

  screen_region_t region;
  cam_side_t      side;
  logic           in_img_rows;
  logic [2:0]     centroid_seg;
  logic [2:0]     bar_level;
  rgb444_t        img_rgb;

  screen_layout_ctrl #(
    .img_cols     (img_cols),
    .img_rows     (img_rows),
    .cam_rght_col (cam_rght_col)
  ) screen_layout_ctrl_i (
    .scan         (scan),
    .region       (region),
    .side         (side),
    .in_img_rows  (in_img_rows),
    .centroid_seg (centroid_seg),
    .bar_level    (bar_level)
  );

  frame_addr_gen #(
    .img_cols     (img_cols),
    .img_rows     (img_rows),
    .cam_rght_col (cam_rght_col)
  ) frame_addr_gen_i (
    .rst          (rst),
    .clk          (clk),
    .scan         (scan),
    .region       (region),
    .side         (side),
    .in_img_rows  (in_img_rows),
    .frame_addr_1 (frame_addr_1),
    .frame_addr_2 (frame_addr_2)
  );

  cam_pixel_fmt cam_pixel_fmt_i (
    .side          (side),
    .rgbmode       (rgbmode),
    .frame_pixel_1 (frame_pixel_1),
    .frame_pixel_2 (frame_pixel_2),
    .img_rgb       (img_rgb)
  );

  pixel_compose pixel_compose_i (
    .region       (region),
    .side         (side),
    .centroid_seg (centroid_seg),
    .bar_level    (bar_level),
    .img_rgb      (img_rgb),
    .cam1_status  (cam1_status),
    .cam2_status  (cam2_status),
    .vga_rgb      (vga_rgb)
  );

endmodule

// File: verilog/pixel_compose.sv
/*
  Final colour mux of the compositor.
  Takes the region and side from the layout control, the formatted
  camera pixel and both camera status words. Paints the proximity bars,
  the centroid band and the filter boxes in the camera's filter colour,
  shows the image in the image region and black everywhere else.
*/
`timescale 1ns/10ps

module pixel_compose (
  input  display_pkg::screen_region_t region,
  input  display_pkg::cam_side_t      side,
  input  logic [2:0]                  centroid_seg,
  input  logic [2:0]                  bar_level,
  input  display_pkg::rgb444_t        img_rgb,
  input  display_pkg::cam_status_t    cam1_status,
  input  display_pkg::cam_status_t    cam2_status,
  output display_pkg::rgb444_t        vga_rgb
);

  import display_pkg::*;

  cam_status_t stat;
  rgb444_t     lit_rgb;
  logic        prox_lit;
  logic        cent_lit;

  assign stat    = (side == cam_right) ? cam1_status : cam2_status;
  assign lit_rgb = expand_filter(stat.filter);

  // the bar grows upwards as proximity rises:
  // proximity 7 lights all levels, proximity 0 only the bottom one
  assign prox_lit = (~stat.proximity <= bar_level);

  assign cent_lit = stat.centroid[centroid_seg];

  always_comb begin
    case (region)
      reg_image:
        vga_rgb = img_rgb;
      reg_prox:
        vga_rgb = prox_lit ? lit_rgb : '0;
      reg_centroid:
        vga_rgb = cent_lit ? lit_rgb : '0;
      reg_filtbox:
        vga_rgb = lit_rgb;  // box always shows the filter colour
      default:
        vga_rgb = '0;       // blank area and blanking interval
    endcase
  end

endmodule

// File: verilog/cam_pixel_fmt.sv
/*
  Picks the buffer word of the camera on the current side and turns it
  into a screen colour. RGB mode splits the word into its three nibbles,
  gray mode puts the green nibble on all channels.
*/
`timescale 1ns/10ps

module cam_pixel_fmt (
  input  display_pkg::cam_side_t  side,
  input  logic                    rgbmode,
  input  display_pkg::buf_pixel_t frame_pixel_1,
  input  display_pkg::buf_pixel_t frame_pixel_2,
  output display_pkg::rgb444_t    img_rgb
);

  import display_pkg::*;

  buf_pixel_t word;

  // right is camera 1, left is camera 2
  assign word = (side == cam_right) ? frame_pixel_1 : frame_pixel_2;

  always_comb begin
    if (rgbmode) begin
      img_rgb.red   = word[11:8];
      img_rgb.green = word[7:4];
      img_rgb.blue  = word[3:0];
    end
    else begin
      // green carries most of the luminance
      img_rgb.red   = word[7:4];
      img_rgb.green = word[7:4];
      img_rgb.blue  = word[7:4];
    end
  end

endmodule

// File: verilog/frame_addr_gen.sv
/*
  Read address counters for the two camera frame buffers.
  An address steps on each new_pxl while the scan is in its camera's
  image. Both clear on every edge once the row is below the image band,
  so the next frame starts again from address zero.
*/
`timescale 1ns/10ps

module frame_addr_gen #(
  parameter int img_cols     = display_pkg::def_img_cols,
  parameter int img_rows     = display_pkg::def_img_rows,
  parameter int cam_rght_col = display_pkg::def_cam_rght_col
) (
  input  logic                        rst,
  input  logic                        clk,
  input  display_pkg::scan_pos_t      scan,
  input  display_pkg::screen_region_t region,
  input  display_pkg::cam_side_t      side,
  input  logic                        in_img_rows,
  output display_pkg::frame_addr_t    frame_addr_1,
  output display_pkg::frame_addr_t    frame_addr_2
);

  import display_pkg::*;

  // last address of one image, wraps there instead of running on
  localparam frame_addr_t last_addr = frame_addr_t'(img_cols * img_rows - 1);

  logic step;

  assign step = scan.new_pxl && (region == reg_image);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frame_addr_1 <= '0;
      frame_addr_2 <= '0;
    end
    else if (!in_img_rows) begin  // below the image, rewind both
      frame_addr_1 <= '0;
      frame_addr_2 <= '0;
    end
    else if (step) begin
      if (side == cam_right)  // camera 1
        frame_addr_1 <= (frame_addr_1 == last_addr) ? '0 : frame_addr_1 + frame_addr_t'(1);
      else                    // camera 2
        frame_addr_2 <= (frame_addr_2 == last_addr) ? '0 : frame_addr_2 + frame_addr_t'(1);
    end
  end

endmodule

// File: verilog/screen_layout_ctrl.sv
/*
  Classifies each scan point into one screen region and one camera side.
  All window bound tests live here, so the address counters and the
  colour mux only look at region and side. Also gives the centroid
  segment under the image and the bar level used by the proximity bars.
*/
`timescale 1ns/10ps

module screen_layout_ctrl #(
  parameter int img_cols     = display_pkg::def_img_cols,
  parameter int img_rows     = display_pkg::def_img_rows,
  parameter int cam_rght_col = display_pkg::def_cam_rght_col
) (
  input  display_pkg::scan_pos_t      scan,
  output display_pkg::screen_region_t region,
  output display_pkg::cam_side_t      side,
  output logic                        in_img_rows,
  output logic [2:0]                  centroid_seg,
  output logic [2:0]                  bar_level
);

  import display_pkg::*;

  // column bounds, each one past the last column of its area
  localparam scr_col_t lft_end       = scr_col_t'(img_cols);
  localparam scr_col_t lft_prox_end  = scr_col_t'(img_cols + ind_width);
  localparam scr_col_t rght_beg      = scr_col_t'(cam_rght_col);
  localparam scr_col_t rght_end      = scr_col_t'(cam_rght_col + img_cols);
  localparam scr_col_t rght_prox_end = scr_col_t'(cam_rght_col + img_cols + ind_width);
  localparam scr_col_t lbox_beg      = scr_col_t'(filtbox_lft_col);
  localparam scr_col_t lbox_end      = scr_col_t'(filtbox_lft_col + ind_width);
  localparam scr_col_t rbox_end      = scr_col_t'(cam_rght_col + ind_width);
  localparam scr_col_t seg_cols      = scr_col_t'(img_cols / 8);  // eight segments

  // row bounds
  localparam scr_row_t img_end  = scr_row_t'(img_rows);
  localparam scr_row_t cent_end = scr_row_t'(img_rows + ind_width);
  localparam scr_row_t box_end  = scr_row_t'(img_rows + 2 * ind_width);

  scr_col_t col;
  scr_row_t row;
  logic     win_left, win_rght;
  logic     prox_left, prox_rght;
  logic     box_left, box_rght;
  logic     rows_cent, rows_box;
  scr_col_t win_offset;
  scr_col_t seg_full;

  assign col = scan.col;
  assign row = scan.row;

  assign win_left  = (col < lft_end);
  assign win_rght  = (col >= rght_beg) && (col < rght_end);
  assign prox_left = (col >= lft_end) && (col < lft_prox_end);
  assign prox_rght = (col >= rght_end) && (col < rght_prox_end);
  assign box_left  = (col >= lbox_beg) && (col < lbox_end);
  assign box_rght  = (col >= rght_beg) && (col < rbox_end);

  assign in_img_rows = (row < img_end);  // no visible term, the counters need it in blanking too
  assign rows_cent   = (row >= img_end) && (row < cent_end);
  assign rows_box    = (row >= cent_end) && (row < box_end);

  assign side = (col >= rght_beg) ? cam_right : cam_left;

  always_comb begin
    region = reg_blank;
    if (scan.visible) begin
      if (in_img_rows) begin
        if (win_left || win_rght)
          region = reg_image;
        else if (prox_left || prox_rght)
          region = reg_prox;
      end
      else if (rows_cent) begin
        if (win_left || win_rght)
          region = reg_centroid;
      end
      else if (rows_box) begin
        if (box_left || box_rght)
          region = reg_filtbox;
      end
    end
  end

  // offset into the image window of the current side
  assign win_offset = (side == cam_right) ? (col - rght_beg) : col;
  assign seg_full   = win_offset / seg_cols;  // only meaningful inside a window

  assign centroid_seg = seg_full[2:0];

  // 128 rows of bar split into 8 steps of 16
  assign bar_level = row[6:4];

endmodule

// File: verilog/display_pkg.sv
/*
  Shared types and layout defaults for the dual camera VGA compositor.
  Every RTL module imports this package inside its body. Port types in
  module headers use scoped names. The layout defaults feed the module
  parameters of the top level, which passes them down.
*/
package display_pkg;

  typedef logic [9:0]  scr_col_t;     // screen column
  typedef logic [9:0]  scr_row_t;     // screen row
  typedef logic [3:0]  nibble_t;      // one colour channel
  typedef logic [11:0] buf_pixel_t;   // r in [11:8], g in [7:4], b in [3:0]
  typedef logic [14:0] frame_addr_t;  // enough for 160x120
  typedef logic [2:0]  filter_rgb_t;  // filter colour bits r, g, b

  typedef struct packed {
    nibble_t red;
    nibble_t green;
    nibble_t blue;
  } rgb444_t;

  // one scan point from the sync generator
  typedef struct packed {
    logic     visible;
    logic     new_pxl;  // one pixel step per high cycle
    scr_col_t col;
    scr_row_t row;
  } scan_pos_t;

  typedef struct packed {
    filter_rgb_t filter;
    logic [7:0]  centroid;   // one bit per horizontal segment
    logic [2:0]  proximity;  // 7 is closest
  } cam_status_t;

  // side picks the camera for every region except reg_blank.
  // the left side is camera 2, the right side camera 1; a point belongs
  // to the right side from cam_rght_col onwards. in reg_blank the side
  // is still driven but nothing reads it
  typedef enum logic {
    cam_left  = 1'b0,
    cam_right = 1'b1
  } cam_side_t;

  typedef enum logic [2:0] {
    reg_blank,
    reg_image,     // camera pixel
    reg_prox,      // proximity bar beside the image
    reg_centroid,  // centroid band under the image
    reg_filtbox    // filter colour box
  } screen_region_t;

  localparam int def_img_cols     = 160;
  localparam int def_img_rows     = 120;
  localparam int def_cam_rght_col = 256;
  localparam int ind_width        = 8;   // bar, band and box size
  localparam int filtbox_lft_col  = 24;

  // each filter bit fills its whole nibble
  function automatic rgb444_t expand_filter(filter_rgb_t filt);
    rgb444_t c;
    c.red   = {4{filt[2]}};
    c.green = {4{filt[1]}};
    c.blue  = {4{filt[0]}};
    return c;
  endfunction

endpackage
